// ==== mac_table_vectors.txt ====
# Idle line holds I and a decimal cycle count
# Lookup line holds L vlan src_mac src_port dst_mac exp_hit exp_port in hex
# Empty table with strobes on consecutive cycles
L 00a 01005e000001 0 020000000099 0 0
L 00a 01005e000001 0 020000000011 0 0
L 00a 01005e000001 0 020000000021 0 0
L 00a 01005e000001 0 ffffffffffff 0 0
I 4
# Learn A on port 3 then look it up
L 00a 020000000011 3 020000000099 0 0
I 7
L 00a 01005e000001 0 020000000011 1 3
# Same address in another VLAN
L 014 01005e000001 0 020000000011 0 0
I 2
# Group source is never learned
L 00a 0300000000aa 5 020000000099 0 0
I 7
L 00a 01005e000001 0 0300000000aa 0 0
I 2
# Five sources back to back while lookups block write-back
L 00a 020000000021 1 020000000099 0 0
L 00a 020000000022 2 020000000099 0 0
L 00a 020000000023 4 020000000099 0 0
L 00a 020000000024 5 020000000099 0 0
L 00a 020000000025 6 020000000099 0 0
L 00a 01005e000001 0 020000000099 0 0
L 00a 01005e000001 0 020000000099 0 0
L 00a 01005e000001 0 020000000099 0 0
I 7
L 00a 01005e000001 0 020000000021 1 1
L 00a 01005e000001 0 020000000022 1 2
L 00a 01005e000001 0 020000000023 1 4
L 00a 01005e000001 0 020000000024 1 5
L 00a 01005e000001 0 020000000025 0 0
I 2
# Five sources in one row, the fifth reuses the first way
L 00a 020000000033 7 020000000099 0 0
I 7
L 00a 020000000133 6 020000000099 0 0
I 7
L 00a 020000000233 5 020000000099 0 0
I 7
L 00a 020000000333 4 020000000099 0 0
I 7
L 00a 020000000433 2 020000000099 0 0
I 7
L 00a 01005e000001 0 020000000033 0 0
L 00a 01005e000001 0 020000000133 1 6
L 00a 01005e000001 0 020000000233 1 5
L 00a 01005e000001 0 020000000333 1 4
L 00a 01005e000001 0 020000000433 1 2

// ==== files.f ====
eth_pkg.sv
mac_table_pkg.sv
mac_index_stage.sv
mac_way_ram.sv
mac_match_stage.sv
mac_learn_queue.sv
mac_table_top.sv
mac_table_assertions.sv
mac_table_tb.sv

// ==== Bender.yml ====
package:
  name: mac_table

sources:
  - eth_pkg.sv
  - mac_table_pkg.sv
  - mac_index_stage.sv
  - mac_way_ram.sv
  - mac_match_stage.sv
  - mac_learn_queue.sv
  - mac_table_top.sv
  - target: test
    files:
      - mac_table_assertions.sv
      - mac_table_tb.sv

// ==== mac_table_tb.sv ====
`timescale 1ns/1ps

module mac_table_tb;

	localparam int NUM_PORTS     = 8;
	localparam int PORT_W        = $clog2(NUM_PORTS);
	localparam int CLK_PERIOD_NS = 40;
	localparam int RESET_CYCLES  = 10;
	localparam int LATENCY       = 2;

	logic              clk = 1'b0;
	logic              arst_n;
	logic              lookup_en;
	eth_pkg::vlan_t    lookup_vlan;
	eth_pkg::mac_t     lookup_src_mac;
	logic [PORT_W-1:0] lookup_src_port;
	eth_pkg::mac_t     lookup_dst_mac;
	logic              lookup_done;
	logic              lookup_hit;
	logic [PORT_W-1:0] lookup_dst_port;

	// Commands from the vector file, one entry per line
	bit             vec_idle_q   [$];
	int             vec_cycles_q [$];
	eth_pkg::vlan_t vec_vlan_q   [$];
	eth_pkg::mac_t  vec_src_q    [$];
	logic [7:0]     vec_sport_q  [$];
	eth_pkg::mac_t  vec_dst_q    [$];
	logic           vec_hit_q    [$];
	logic [7:0]     vec_port_q   [$];

	// Lookups in flight, oldest at the front
	int         issue_q    [$];
	int         seq_q      [$];
	logic       exp_hit_q  [$];
	logic [7:0] exp_port_q [$];

	int tick;
	int lookup_count;
	int checked_count;
	int value_errors;
	int other_errors;
	int watchdog_cycles;

	mac_table_top mac_table_top_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.lookup_en      (lookup_en),
		.lookup_vlan    (lookup_vlan),
		.lookup_src_mac (lookup_src_mac),
		.lookup_src_port(lookup_src_port),
		.lookup_dst_mac (lookup_dst_mac),
		.lookup_done    (lookup_done),
		.lookup_hit     (lookup_hit),
		.lookup_dst_port(lookup_dst_port)
	);

	always #(CLK_PERIOD_NS / 2) clk = ~clk;

	////////////////////
	// Helpers

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, actual,
				expected);
			value_errors++;
		end
	endtask

	// Idle lines get 0 to 3 extra cycles of jitter
	task automatic read_vectors(output bit ok);
		int               fd;
		int               code;
		int               cycles;
		bit               at_end;
		logic [63:0]      word;
		logic [8*128-1:0] rest;
		logic [11:0]      vlan;
		logic [47:0]      src;
		logic [47:0]      dst;
		logic [7:0]       sport;
		logic [7:0]       hit;
		logic [7:0]       port;
		ok     = 1'b1;
		at_end = 1'b0;
		fd     = $fopen("mac_table_vectors.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open mac_table_vectors.txt");
			ok = 1'b0;
		end else begin
			while (ok && !at_end) begin
				word = '0;
				code = $fscanf(fd, "%s", word);
				if (code != 1) begin
					at_end = 1'b1;
				end else if (word == "#") begin
					code = $fgets(rest, fd);
				end else if (word == "I") begin
					code = $fscanf(fd, "%d", cycles);
					if (code != 1 || cycles < 0) begin
						$display("Error: bad idle line in mac_table_vectors.txt");
						ok = 1'b0;
					end else begin
						vec_idle_q.push_back(1'b1);
						vec_cycles_q.push_back(cycles + int'($urandom % 4));
						vec_vlan_q.push_back('0);
						vec_src_q.push_back('0);
						vec_sport_q.push_back('0);
						vec_dst_q.push_back('0);
						vec_hit_q.push_back(1'b0);
						vec_port_q.push_back('0);
					end
				end else if (word == "L") begin
					code = $fscanf(fd, "%h %h %h %h %h %h", vlan, src, sport, dst, hit, port);
					if (code != 6) begin
						$display("Error: bad lookup line in mac_table_vectors.txt");
						ok = 1'b0;
					end else begin
						vec_idle_q.push_back(1'b0);
						vec_cycles_q.push_back(0);
						vec_vlan_q.push_back(vlan);
						vec_src_q.push_back(src);
						vec_sport_q.push_back(sport);
						vec_dst_q.push_back(dst);
						vec_hit_q.push_back(hit != 0);
						vec_port_q.push_back(port);
					end
				end else begin
					$display("Error: unknown command in mac_table_vectors.txt");
					ok = 1'b0;
				end
			end
			$fclose(fd);
		end
	endtask

	// Result sampled mid-cycle, in order of issue
	task automatic compare_results();
		if (lookup_done) begin
			if (issue_q.size() == 0) begin
				$display("Error at %0t ns: lookup_done with no lookup outstanding", $time);
				other_errors++;
			end else begin
				check_value(64'(tick - issue_q[0]), 64'(LATENCY),
					$sformatf("lookup %0d latency", seq_q[0]));
				check_value(64'(lookup_hit), 64'(exp_hit_q[0]),
					$sformatf("lookup %0d hit", seq_q[0]));
				// Port only meaningful on a hit
				if (exp_hit_q[0]) begin
					check_value(64'(lookup_dst_port), 64'(exp_port_q[0][PORT_W-1:0]),
						$sformatf("lookup %0d port", seq_q[0]));
				end
				checked_count++;
				void'(issue_q.pop_front());
				void'(seq_q.pop_front());
				void'(exp_hit_q.pop_front());
				void'(exp_port_q.pop_front());
			end
		end else begin
			check_value(64'(lookup_hit), 64'(0), "lookup_hit outside lookup_done");
			if (issue_q.size() > 0 && tick > issue_q[0] + LATENCY) begin
				$display("Error at %0t ns: lookup %0d never got lookup_done", $time, seq_q[0]);
				other_errors++;
				void'(issue_q.pop_front());
				void'(seq_q.pop_front());
				void'(exp_hit_q.pop_front());
				void'(exp_port_q.pop_front());
			end
		end
	endtask

	// Falling edge, check first, then drive
	task automatic advance_cycle();
		@(negedge clk);
		tick++;
		compare_results();
	endtask

	task automatic drive_lookup(input int idx);
		lookup_en       = 1'b1;
		lookup_vlan     = vec_vlan_q[idx];
		lookup_src_mac  = vec_src_q[idx];
		lookup_src_port = vec_sport_q[idx][PORT_W-1:0];
		lookup_dst_mac  = vec_dst_q[idx];
		issue_q.push_back(tick);
		seq_q.push_back(lookup_count);
		exp_hit_q.push_back(vec_hit_q[idx]);
		exp_port_q.push_back(vec_port_q[idx]);
		lookup_count++;
	endtask

	////////////////////
	// Main sequence

	initial begin
		bit load_ok;
		int total_idle;
		arst_n          = 1'b0;
		lookup_en       = 1'b0;
		lookup_vlan     = '0;
		lookup_src_mac  = '0;
		lookup_src_port = '0;
		lookup_dst_mac  = '0;
		tick            = 0;
		lookup_count    = 0;
		checked_count   = 0;
		value_errors    = 0;
		other_errors    = 0;
		void'($urandom(20));
		read_vectors(load_ok);
		if (!load_ok) begin
			$display("Error: no usable vectors, run stopped");
			$display("Something failed");
			$finish;
		end else begin
			total_idle = 0;
			foreach (vec_cycles_q[i]) begin
				total_idle += vec_cycles_q[i];
			end
			watchdog_cycles = vec_idle_q.size() + total_idle + 50;
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			arst_n = 1'b1;
			foreach (vec_idle_q[i]) begin
				if (vec_idle_q[i]) begin
					repeat (vec_cycles_q[i]) begin
						advance_cycle();
						lookup_en = 1'b0;
					end
				end else begin
					advance_cycle();
					drive_lookup(i);
				end
			end
			// Let the last results come out
			advance_cycle();
			lookup_en = 1'b0;
			while (issue_q.size() > 0) begin
				advance_cycle();
			end
			$display("Summary: %0d lookups sent, %0d checked, %0d value errors, %0d other errors",
				lookup_count, checked_count, value_errors, other_errors);
			if (value_errors == 0 && other_errors == 0 && checked_count == lookup_count) begin
				$display("Everything OK");
			end else begin
				$display("Something failed");
			end
			$finish;
		end
	end

	// Limit from the vector count and idle total
	initial begin
		wait (watchdog_cycles > 0);
		#(watchdog_cycles * CLK_PERIOD_NS);
		$display("Error: timeout, the run did not end within %0d cycles", watchdog_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== mac_table_assertions.sv ====
`timescale 1ns/1ps

module mac_table_assertions #(
	parameter int PENDING_SIZE = 4
) (
	input logic clk,
	input logic arst_n,
	input logic lookup_en,
	input logic lookup_done,
	input logic lookup_hit,
	input logic wr_req
);

	////////////////////
	// Lookup timing

	// Index stage then match stage, two flops
	a_done_follows_en: assert property (@(posedge clk) disable iff (!arst_n)
		lookup_en |-> ##2 lookup_done)
		else $error("lookup_done missing two cycles after lookup_en");

	// No result without a strobe two cycles back
	a_done_has_en: assert property (@(posedge clk) disable iff (!arst_n)
		lookup_done |-> $past(lookup_en, 2))
		else $error("lookup_done without lookup_en two cycles earlier");

	a_hit_with_done: assert property (@(posedge clk) disable iff (!arst_n)
		lookup_hit |-> lookup_done)
		else $error("lookup_hit high without lookup_done");

	////////////////////
	// Port B sharing

	// Idle cycles go to write-back
	// A full queue plus two late learns is empty within PENDING_SIZE+3 of them
	a_queue_drains: assert property (@(posedge clk) disable iff (!arst_n)
		!lookup_en [*PENDING_SIZE+3] |-> !wr_req)
		else $error("learn queue still holds writes after idle cycles");

endmodule

bind mac_table_top mac_table_assertions #(
	.PENDING_SIZE(PENDING_SIZE)
) mac_table_assertions_inst (
	.clk        (clk),
	.arst_n     (arst_n),
	.lookup_en  (lookup_en),
	.lookup_done(lookup_done),
	.lookup_hit (lookup_hit),
	.wr_req     (wr_req)
);

// ==== mac_table_top.sv ====
`timescale 1ns/1ps

module mac_table_top #(
	parameter int TABLE_ROWS   = 64,
	parameter int ASSOC_WAYS   = 4,
	parameter int PENDING_SIZE = 4,
	parameter int NUM_PORTS    = 8,
	localparam int ROW_BITS   = $clog2(TABLE_ROWS),
	localparam int ASSOC_BITS = $clog2(ASSOC_WAYS),
	localparam int PORT_W     = $clog2(NUM_PORTS)
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              lookup_en,
	input  eth_pkg::vlan_t    lookup_vlan,
	input  eth_pkg::mac_t     lookup_src_mac,
	input  logic [PORT_W-1:0] lookup_src_port,
	input  eth_pkg::mac_t     lookup_dst_mac,
	output logic              lookup_done,
	output logic              lookup_hit,
	output logic [PORT_W-1:0] lookup_dst_port
);

	// Learn queue to index stage
	logic                  wr_req;
	logic                  wr_grant;
	logic [ROW_BITS-1:0]   wr_row;
	logic [ASSOC_BITS-1:0] wr_way;
	mac_table_pkg::entry_t wr_entry;

	// Index stage to way RAMs
	logic                  rd_a_en;
	logic [ROW_BITS-1:0]   rd_a_row;
	logic                  b_en;
	logic [ROW_BITS-1:0]   b_row;
	logic [ASSOC_WAYS-1:0] b_we;
	mac_table_pkg::entry_t b_wdata;
	mac_table_pkg::entry_t a_rdata [ASSOC_WAYS];
	mac_table_pkg::entry_t b_rdata [ASSOC_WAYS];

	// Stage 1 fields
	logic                stage1_valid;
	eth_pkg::vlan_t      s1_vlan;
	eth_pkg::mac_t       s1_src_mac;
	logic [PORT_W-1:0]   s1_src_port;
	eth_pkg::mac_t       s1_dst_mac;
	logic [ROW_BITS-1:0] s1_src_row;

	// Match stage to learn queue
	logic                learn_req;
	eth_pkg::mac_t       learn_mac;
	eth_pkg::vlan_t      learn_vlan;
	logic [PORT_W-1:0]   learn_port;
	logic [ROW_BITS-1:0] learn_row;

	mac_index_stage #(
		.TABLE_ROWS(TABLE_ROWS),
		.ASSOC_WAYS(ASSOC_WAYS),
		.NUM_PORTS (NUM_PORTS)
	) mac_index_stage_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.lookup_en      (lookup_en),
		.lookup_vlan    (lookup_vlan),
		.lookup_src_mac (lookup_src_mac),
		.lookup_src_port(lookup_src_port),
		.lookup_dst_mac (lookup_dst_mac),
		.wr_req         (wr_req),
		.wr_row         (wr_row),
		.wr_way         (wr_way),
		.wr_entry       (wr_entry),
		.wr_grant       (wr_grant),
		.rd_a_en        (rd_a_en),
		.rd_a_row       (rd_a_row),
		.b_en           (b_en),
		.b_row          (b_row),
		.b_we           (b_we),
		.b_wdata        (b_wdata),
		.stage1_valid   (stage1_valid),
		.s1_vlan        (s1_vlan),
		.s1_src_mac     (s1_src_mac),
		.s1_src_port    (s1_src_port),
		.s1_dst_mac     (s1_dst_mac),
		.s1_src_row     (s1_src_row)
	);

	// One memory per way, all share the row addresses
	for (genvar g = 0; g < ASSOC_WAYS; g++) begin : gen_way
		mac_way_ram #(
			.TABLE_ROWS(TABLE_ROWS)
		) mac_way_ram_inst (
			.clk    (clk),
			.arst_n (arst_n),
			.a_en   (rd_a_en),
			.a_row  (rd_a_row),
			.b_en   (b_en),
			.b_row  (b_row),
			.b_we   (b_we[g]),
			.b_wdata(b_wdata),
			.a_rdata(a_rdata[g]),
			.b_rdata(b_rdata[g])
		);
	end

	mac_match_stage #(
		.TABLE_ROWS(TABLE_ROWS),
		.ASSOC_WAYS(ASSOC_WAYS),
		.NUM_PORTS (NUM_PORTS)
	) mac_match_stage_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.stage1_valid   (stage1_valid),
		.s1_vlan        (s1_vlan),
		.s1_src_mac     (s1_src_mac),
		.s1_src_port    (s1_src_port),
		.s1_dst_mac     (s1_dst_mac),
		.s1_src_row     (s1_src_row),
		.a_rdata        (a_rdata),
		.b_rdata        (b_rdata),
		.lookup_done    (lookup_done),
		.lookup_hit     (lookup_hit),
		.lookup_dst_port(lookup_dst_port),
		.learn_req      (learn_req),
		.learn_mac      (learn_mac),
		.learn_vlan     (learn_vlan),
		.learn_port     (learn_port),
		.learn_row      (learn_row)
	);

	mac_learn_queue #(
		.TABLE_ROWS  (TABLE_ROWS),
		.ASSOC_WAYS  (ASSOC_WAYS),
		.PENDING_SIZE(PENDING_SIZE),
		.NUM_PORTS   (NUM_PORTS)
	) mac_learn_queue_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.learn_req (learn_req),
		.learn_mac (learn_mac),
		.learn_vlan(learn_vlan),
		.learn_port(learn_port),
		.learn_row (learn_row),
		.wr_grant  (wr_grant),
		.wr_req    (wr_req),
		.wr_row    (wr_row),
		.wr_way    (wr_way),
		.wr_entry  (wr_entry)
	);

endmodule

// ==== mac_learn_queue.sv ====
`timescale 1ns/1ps

module mac_learn_queue #(
	parameter int TABLE_ROWS   = 64,
	parameter int ASSOC_WAYS   = 4,
	parameter int PENDING_SIZE = 4,
	parameter int NUM_PORTS    = 8,
	localparam int ROW_BITS   = $clog2(TABLE_ROWS),
	localparam int ASSOC_BITS = $clog2(ASSOC_WAYS),
	localparam int SLOT_BITS  = $clog2(PENDING_SIZE),
	localparam int PORT_W     = $clog2(NUM_PORTS)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  learn_req,
	input  eth_pkg::mac_t         learn_mac,
	input  eth_pkg::vlan_t        learn_vlan,
	input  logic [PORT_W-1:0]     learn_port,
	input  logic [ROW_BITS-1:0]   learn_row,
	input  logic                  wr_grant,
	output logic                  wr_req,
	output logic [ROW_BITS-1:0]   wr_row,
	output logic [ASSOC_BITS-1:0] wr_way,
	output mac_table_pkg::entry_t wr_entry
);

	// Pending slots
	logic [PENDING_SIZE-1:0] slot_valid;
	mac_table_pkg::entry_t   slot_entry [PENDING_SIZE];
	logic [ROW_BITS-1:0]     slot_row   [PENDING_SIZE];
	logic [ASSOC_BITS-1:0]   slot_way   [PENDING_SIZE];

	// Sequential replacement
	logic [ASSOC_BITS-1:0] way_cnt;

	logic                 dup;
	logic                 accept;
	logic [SLOT_BITS-1:0] free_slot;
	logic [SLOT_BITS-1:0] head_slot;

	////////////////////
	// Slot search

	always_comb begin
		dup       = 1'b0;
		free_slot = '0;
		head_slot = '0;
		// Same address, VLAN and port already waiting
		for (int i = 0; i < PENDING_SIZE; i++) begin
			if (slot_valid[i] && (slot_entry[i].mac == learn_mac) &&
				(slot_entry[i].vlan == learn_vlan) &&
				(slot_entry[i].port[PORT_W-1:0] == learn_port)) begin
				dup = 1'b1;
			end
		end
		// Downward scan leaves the lowest index
		for (int i = PENDING_SIZE - 1; i >= 0; i--) begin
			if (!slot_valid[i]) begin
				free_slot = SLOT_BITS'(i);
			end
			if (slot_valid[i]) begin
				head_slot = SLOT_BITS'(i);
			end
		end
	end

	// Dropped when full or duplicate, counter then stays put
	assign accept = learn_req && !dup && !(&slot_valid);

	////////////////////
	// Slot state

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= '0;
			way_cnt    <= '0;
		end else begin
			// Head is valid, so it never equals the free slot
			if (wr_grant) begin
				slot_valid[head_slot] <= 1'b0;
			end
			if (accept) begin
				slot_valid[free_slot] <= 1'b1;
				if (way_cnt == ASSOC_BITS'(ASSOC_WAYS - 1)) begin
					way_cnt <= '0;
				end else begin
					way_cnt <= way_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			slot_entry[free_slot].valid <= 1'b1;
			slot_entry[free_slot].vlan  <= learn_vlan;
			slot_entry[free_slot].port  <= mac_table_pkg::PORT_W_MAX'(learn_port);
			slot_entry[free_slot].mac   <= learn_mac;
			slot_row[free_slot]         <= learn_row;
			slot_way[free_slot]         <= way_cnt;
		end
	end

	////////////////////
	// Write-back

	// Held until granted, next slot shows up the cycle after
	assign wr_req   = |slot_valid;
	assign wr_row   = slot_row[head_slot];
	assign wr_way   = slot_way[head_slot];
	assign wr_entry = slot_entry[head_slot];

endmodule

// ==== mac_match_stage.sv ====
`timescale 1ns/1ps

module mac_match_stage #(
	parameter int TABLE_ROWS = 64,
	parameter int ASSOC_WAYS = 4,
	parameter int NUM_PORTS  = 8,
	localparam int ROW_BITS  = $clog2(TABLE_ROWS),
	localparam int PORT_W    = $clog2(NUM_PORTS)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  stage1_valid,
	input  eth_pkg::vlan_t        s1_vlan,
	input  eth_pkg::mac_t         s1_src_mac,
	input  logic [PORT_W-1:0]     s1_src_port,
	input  eth_pkg::mac_t         s1_dst_mac,
	input  logic [ROW_BITS-1:0]   s1_src_row,
	input  mac_table_pkg::entry_t a_rdata [ASSOC_WAYS],
	input  mac_table_pkg::entry_t b_rdata [ASSOC_WAYS],
	output logic                  lookup_done,
	output logic                  lookup_hit,
	output logic [PORT_W-1:0]     lookup_dst_port,
	output logic                  learn_req,
	output eth_pkg::mac_t         learn_mac,
	output eth_pkg::vlan_t        learn_vlan,
	output logic [PORT_W-1:0]     learn_port,
	output logic [ROW_BITS-1:0]   learn_row
);

	logic              dst_hit;
	logic [PORT_W-1:0] dst_port;
	logic              src_known;
	logic              src_learn;

	////////////////////
	// Way compare

	always_comb begin
		dst_hit   = 1'b0;
		dst_port  = '0;
		src_known = 1'b0;
		// Ascending scan, so the highest hitting way is kept
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (a_rdata[w].valid && (a_rdata[w].vlan == s1_vlan) &&
				(a_rdata[w].mac == s1_dst_mac)) begin
				dst_hit  = 1'b1;
				dst_port = a_rdata[w].port[PORT_W-1:0];
			end
			// Port is ignored here, a moved station keeps its old entry
			if (b_rdata[w].valid && (b_rdata[w].vlan == s1_vlan) &&
				(b_rdata[w].mac == s1_src_mac)) begin
				src_known = 1'b1;
			end
		end
	end

	// Group addresses are never learned
	assign src_learn = stage1_valid && !src_known && !s1_src_mac[eth_pkg::MCAST_BIT];

	////////////////////
	// Result registers

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lookup_done     <= 1'b0;
			lookup_hit      <= 1'b0;
			lookup_dst_port <= '0;
			learn_req       <= 1'b0;
		end else begin
			lookup_done     <= stage1_valid;
			lookup_hit      <= stage1_valid && dst_hit;
			lookup_dst_port <= dst_port;
			learn_req       <= src_learn;
		end
	end

	// Learn fields, sampled with the request
	always_ff @(posedge clk) begin
		if (src_learn) begin
			learn_mac  <= s1_src_mac;
			learn_vlan <= s1_vlan;
			learn_port <= s1_src_port;
			learn_row  <= s1_src_row;
		end
	end

endmodule

// ==== mac_way_ram.sv ====
`timescale 1ns/1ps

module mac_way_ram #(
	parameter int TABLE_ROWS = 64,
	localparam int ROW_BITS  = $clog2(TABLE_ROWS)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  a_en,
	input  logic [ROW_BITS-1:0]   a_row,
	input  logic                  b_en,
	input  logic [ROW_BITS-1:0]   b_row,
	input  logic                  b_we,
	input  mac_table_pkg::entry_t b_wdata,
	output mac_table_pkg::entry_t a_rdata,
	output mac_table_pkg::entry_t b_rdata
);

	// Address, VLAN and port per row
	mac_table_pkg::entry_t mem [TABLE_ROWS];
	// Valid flags kept apart so the table clears on reset
	logic [TABLE_ROWS-1:0] valid;

	mac_table_pkg::entry_t a_data_q;
	mac_table_pkg::entry_t b_data_q;
	logic                  a_valid_q;
	logic                  b_valid_q;

	////////////////////
	// Storage

	always_ff @(posedge clk) begin
		if (b_en && b_we) begin
			mem[b_row] <= b_wdata;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (b_en && b_we) begin
			valid[b_row] <= b_wdata.valid;
		end
	end

	////////////////////
	// Read ports

	// Registered data, read-first on a write to the same row
	always_ff @(posedge clk) begin
		if (a_en) begin
			a_data_q <= mem[a_row];
		end
		if (b_en) begin
			b_data_q <= mem[b_row];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			a_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (a_en) begin
				a_valid_q <= valid[a_row];
			end
			if (b_en) begin
				b_valid_q <= valid[b_row];
			end
		end
	end

	// Flop valid overrides the stored copy
	always_comb begin
		a_rdata       = a_data_q;
		a_rdata.valid = a_valid_q;
		b_rdata       = b_data_q;
		b_rdata.valid = b_valid_q;
	end

endmodule

// ==== mac_index_stage.sv ====
`timescale 1ns/1ps

module mac_index_stage #(
	parameter int TABLE_ROWS = 64,
	parameter int ASSOC_WAYS = 4,
	parameter int NUM_PORTS  = 8,
	localparam int ROW_BITS   = $clog2(TABLE_ROWS),
	localparam int ASSOC_BITS = $clog2(ASSOC_WAYS),
	localparam int PORT_W     = $clog2(NUM_PORTS)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  lookup_en,
	input  eth_pkg::vlan_t        lookup_vlan,
	input  eth_pkg::mac_t         lookup_src_mac,
	input  logic [PORT_W-1:0]     lookup_src_port,
	input  eth_pkg::mac_t         lookup_dst_mac,
	input  logic                  wr_req,
	input  logic [ROW_BITS-1:0]   wr_row,
	input  logic [ASSOC_BITS-1:0] wr_way,
	input  mac_table_pkg::entry_t wr_entry,
	output logic                  wr_grant,
	output logic                  rd_a_en,
	output logic [ROW_BITS-1:0]   rd_a_row,
	output logic                  b_en,
	output logic [ROW_BITS-1:0]   b_row,
	output logic [ASSOC_WAYS-1:0] b_we,
	output mac_table_pkg::entry_t b_wdata,
	output logic                  stage1_valid,
	output eth_pkg::vlan_t        s1_vlan,
	output eth_pkg::mac_t         s1_src_mac,
	output logic [PORT_W-1:0]     s1_src_port,
	output eth_pkg::mac_t         s1_dst_mac,
	output logic [ROW_BITS-1:0]   s1_src_row
);

	logic [15:0]         src_hash;
	logic [15:0]         dst_hash;
	logic [ROW_BITS-1:0] src_row;
	logic [ROW_BITS-1:0] dst_row;

	////////////////////
	// Row hashing

	// Both addresses hash in the packet VLAN
	assign src_hash = mac_table_pkg::row_hash(lookup_src_mac, lookup_vlan, ROW_BITS);
	assign dst_hash = mac_table_pkg::row_hash(lookup_dst_mac, lookup_vlan, ROW_BITS);
	assign src_row  = src_hash[ROW_BITS-1:0];
	assign dst_row  = dst_hash[ROW_BITS-1:0];

	////////////////////
	// Port arbitration

	// Port A only ever serves the destination read
	assign rd_a_en  = lookup_en;
	assign rd_a_row = dst_row;

	// Port B: source read wins, a pending write gets the idle cycles
	assign wr_grant = wr_req && !lookup_en;
	assign b_en     = lookup_en || wr_grant;
	assign b_row    = lookup_en ? src_row : wr_row;
	// One-hot enable, only the chosen way is written
	assign b_we     = wr_grant ? (ASSOC_WAYS'(1) << wr_way) : '0;
	assign b_wdata  = wr_entry;

	////////////////////
	// Request pipeline

	// Strobe lines up with RAM read data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stage1_valid <= 1'b0;
		end else begin
			stage1_valid <= lookup_en;
		end
	end

	// Fields only change with a new packet
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			s1_vlan     <= lookup_vlan;
			s1_src_mac  <= lookup_src_mac;
			s1_src_port <= lookup_src_port;
			s1_dst_mac  <= lookup_dst_mac;
			s1_src_row  <= src_row;
		end
	end

endmodule

// ==== mac_table_pkg.sv ====
package mac_table_pkg;

	////////////////////
	// Stored entry

	// Widest port number the entry can carry
	// Modules keep only the low clog2(NUM_PORTS) bits
	localparam int PORT_W_MAX = 8;

	// One way of one row
	typedef struct packed {
		logic                  valid;
		eth_pkg::vlan_t        vlan;
		logic [PORT_W_MAX-1:0] port;
		eth_pkg::mac_t         mac;
	} entry_t;

	////////////////////
	// Row indexing

	// XOR fold of the address and VLAN down to 16 bits
	// Bits above row_bits are cleared, caller slices the low part
	function automatic logic [15:0] row_hash(input eth_pkg::mac_t mac, input eth_pkg::vlan_t vlan,
		input int row_bits);
		logic [15:0] fold;
		fold = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {4'h0, vlan};
		return fold & ((16'h1 << row_bits) - 16'h1);
	endfunction

endpackage

// ==== eth_pkg.sv ====
package eth_pkg;

	////////////////////
	// Address fields

	// Station address, transmitted first octet in bits 47:40
	typedef logic [47:0] mac_t;

	////////////////////
	// Tag fields

	// VLAN ID from the 802.1Q tag
	// Untagged traffic is expected on the port default VLAN
	typedef logic [11:0] vlan_t;

	////////////////////
	// Address classes

	// Group bit of the first octet
	// Set for multicast and broadcast, never for a unicast station
	localparam int MCAST_BIT = 40;

endpackage
